//--- z80_seq.f
src/z80_pkg.sv
src/z80_mem_if.sv
src/z80_decoder.sv
src/z80_regfile.sv
src/z80_apb_master.sv
src/z80_sequencer.sv
src/z80_core.sv
bench/tb_z80_core.sv

//--- Makefile
TOP := tb_z80_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# The run passes only if the pass line shows up in the simulation output
test:
	verilator --binary --timing -f z80_seq.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "^NO ERRORS$$" > /dev/null

clean:
	rm -rf obj_dir

//--- bench/tb_z80_core.sv
module tb_z80_core;

    timeunit 1ns;
    timeprecision 100ps;

    logic            clk;
    logic            reset;
    logic            o_psel;
    logic            o_penable;
    logic            o_pwrite;
    z80_pkg::addr_t  o_paddr;
    z80_pkg::byte_t  o_pwdata;
    z80_pkg::byte_t  i_prdata;
    logic            i_pready;
    logic            o_insn_done;

    z80_pkg::byte_t  mem [0:65535];
    z80_pkg::addr_t  xfer_addr [$];
    logic            xfer_we [$];
    z80_pkg::addr_t  load_ptr;
    logic [15:0]     lfsr_state;
    logic            stall_on;
    int              stall_left;
    int              stall_cycles;
    int              done_count;
    int              n_checks;
    int              n_mismatch;
    int              n_fail;

    z80_core #(
        .P_RESET_PC (16'h0000)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .o_psel      (o_psel),
        .o_penable   (o_penable),
        .o_pwrite    (o_pwrite),
        .o_paddr     (o_paddr),
        .o_pwdata    (o_pwdata),
        .i_prdata    (i_prdata),
        .i_pready    (i_pready),
        .o_insn_done (o_insn_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val;
    endfunction

    function automatic z80_pkg::byte_t fill_byte(input z80_pkg::addr_t a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'h5A;
    endfunction

    // Memory side of the transfer ends in time for the next rising edge
    task automatic complete_transfer();
        if (o_pwrite) begin
            mem[o_paddr] = o_pwdata;
        end else begin
            i_prdata = mem[o_paddr];
        end
        i_pready = 1'b1;
        xfer_addr.push_back(o_paddr);
        xfer_we.push_back(o_pwrite);
    endtask

    always @(negedge clk) begin
        if (o_insn_done) begin
            done_count++;
        end
        if (o_psel && !o_penable) begin
            stall_left = stall_on ? take_bits(2) : 0;
            if (stall_left == 0) begin
                complete_transfer();
            end else begin
                i_pready = 1'b0;
            end
        end else if (o_psel && o_penable) begin
            if (!i_pready) begin
                stall_left--;
                if (stall_left == 0) begin
                    complete_transfer();
                end else begin
                    stall_cycles++;
                end
            end
        end else begin
            i_pready = 1'b0;
        end
    end

    task automatic compare_byte(input z80_pkg::byte_t got, input z80_pkg::byte_t exp,
                                input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(input z80_pkg::addr_t got, input z80_pkg::addr_t exp,
                                input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s is %04h, expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // The DUT is held in reset while memory is rewritten
    task automatic begin_test();
        z80_pkg::addr_t a16;
        reset = 1'b1;
        for (int a = 0; a < 65536; a++) begin
            a16 = 16'(a);
            mem[a16] = fill_byte(a16);
        end
        load_ptr = 16'h0000;
        xfer_addr.delete();
        xfer_we.delete();
        done_count = 0;
    endtask

    task automatic emit_byte(input z80_pkg::byte_t b);
        mem[load_ptr] = b;
        load_ptr = load_ptr + 16'd1;
    endtask

    task automatic run_program(input int n_insn, input int n_xfers);
        int cycles;
        logic finished;
        cycles = 0;
        finished = 1'b0;
        repeat (3) begin
            @(negedge clk);
            compare_bit(o_psel, 1'b0, "psel during reset");
            compare_bit(o_penable, 1'b0, "penable during reset");
            compare_bit(o_pwrite, 1'b0, "pwrite during reset");
            compare_bit(o_insn_done, 1'b0, "insn_done during reset");
        end
        reset = 1'b0;
        // The program ends with the done pulse after its last transfer
        while (!finished && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            finished = (xfer_addr.size() >= n_xfers) && o_insn_done;
        end
        // Stop before the fetch that follows the program
        reset = 1'b1;
        if (!finished) begin
            n_fail++;
            $display("Timeout: %0d of %0d transfers and no final done pulse within %0d cycles",
                     xfer_addr.size(), n_xfers, cycles);
        end
        @(posedge clk);
        compare_count(done_count, n_insn, "done pulses");
        compare_count(xfer_addr.size(), n_xfers, "APB transfers");
    endtask

    function automatic int count_writes();
        int n;
        n = 0;
        foreach (xfer_we[i]) begin
            if (xfer_we[i]) n++;
        end
        return n;
    endfunction

    // NOP, LD A,n, HALT and RET as no-ops, then LD (9000),A
    task automatic fetch_order_test();
        z80_pkg::byte_t prog [8] = '{8'h00, 8'h3E, 8'h5A, 8'h76, 8'hC9, 8'h32, 8'h00, 8'h90};
        begin_test();
        foreach (prog[i]) emit_byte(prog[i]);
        run_program(5, 9);
        for (int i = 0; i < 8 && i < xfer_addr.size(); i++) begin
            compare_addr(xfer_addr[i], 16'(i), $sformatf("transfer %0d address", i));
            compare_bit(xfer_we[i], 1'b0, $sformatf("transfer %0d write", i));
        end
        if (xfer_addr.size() > 8) begin
            compare_addr(xfer_addr[8], 16'h9000, "store address");
            compare_bit(xfer_we[8], 1'b1, "store write");
        end
        compare_byte(mem[16'h9000], 8'h5A, "byte at 9000");
        compare_count(count_writes(), 1, "APB writes");
    endtask

    task automatic immediate_store_test();
        z80_pkg::addr_t dst [4] = '{16'h8000, 16'h8123, 16'hC0DE, 16'h7FFF};
        z80_pkg::byte_t val [4] = '{8'h11, 8'hA5, 8'h3C, 8'hF0};
        begin_test();
        for (int k = 0; k < 4; k++) begin
            emit_byte(8'h3E);
            emit_byte(val[k]);
            emit_byte(8'h32);
            emit_byte(dst[k][7:0]);
            emit_byte(dst[k][15:8]);
        end
        run_program(8, 24);
        for (int k = 0; k < 4; k++) begin
            compare_byte(mem[dst[k]], val[k], $sformatf("byte at %04h", dst[k]));
        end
    endtask

    // B=77, A=B, BC/DE/HL loaded, (DE)=A, (HL)=C3, C=(HL), new HL, (HL)=C
    task automatic indirect_access_test();
        z80_pkg::byte_t prog [22] = '{8'h06, 8'h77, 8'h78, 8'h01, 8'h00, 8'hA0,
                                      8'h11, 8'h10, 8'hA0, 8'h21, 8'h20, 8'hA0,
                                      8'h12, 8'h36, 8'hC3, 8'h4E, 8'h21, 8'h30,
                                      8'hA0, 8'h71, 8'h00, 8'h00};
        begin_test();
        foreach (prog[i]) emit_byte(prog[i]);
        run_program(10, 24);
        compare_byte(mem[16'hA010], 8'h77, "byte at A010");
        compare_byte(mem[16'hA020], 8'hC3, "byte at A020");
        compare_byte(mem[16'hA030], 8'hC3, "byte at A030");
        compare_byte(mem[16'hA000], fill_byte(16'hA000), "byte at A000");
        compare_count(count_writes(), 3, "APB writes");
    endtask

    // BC=B040, A=(B100), (BC)=A
    task automatic memory_read_test();
        z80_pkg::byte_t prog [7] = '{8'h01, 8'h40, 8'hB0, 8'h3A, 8'h00, 8'hB1, 8'h02};
        begin_test();
        foreach (prog[i]) emit_byte(prog[i]);
        run_program(3, 9);
        compare_byte(mem[16'hB040], fill_byte(16'hB100), "byte at B040");
        compare_count(count_writes(), 1, "APB writes");
    endtask

    initial begin
        reset = 1'b1;
        i_pready = 1'b0;
        i_prdata = 8'h00;
        stall_on = 1'b0;
        stall_left = 0;
        stall_cycles = 0;
        done_count = 0;
        load_ptr = 16'h0000;
        lfsr_state = 16'd24999;
        n_checks = 0;
        n_mismatch = 0;
        n_fail = 0;

        fetch_order_test();
        immediate_store_test();
        indirect_access_test();
        memory_read_test();

        // Same programs with random wait states
        stall_on = 1'b1;
        immediate_store_test();
        indirect_access_test();
        memory_read_test();
        if (stall_cycles == 0) begin
            n_fail++;
            $display("The back-pressure runs never held pready low");
        end

        $display("Checks %0d, mismatches %0d, other failures %0d",
                 n_checks, n_mismatch, n_fail);
        if (n_mismatch == 0 && n_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- src/z80_core.sv
module z80_core #(
    parameter z80_pkg::addr_t P_RESET_PC = 16'h0000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            o_psel,
    output logic            o_penable,
    output logic            o_pwrite,
    output z80_pkg::addr_t  o_paddr,
    output z80_pkg::byte_t  o_pwdata,
    input  z80_pkg::byte_t  i_prdata,
    input  logic            i_pready,
    output logic            o_insn_done
);

    z80_mem_if mem_bus ();

    z80_pkg::byte_t        opcode;
    z80_pkg::insn_group_t  group;
    z80_pkg::insn_len_t    len;
    z80_pkg::reg_sel_t     rd_sel;
    z80_pkg::byte_t        rd_data;
    z80_pkg::pair_sel_t    pair_sel;
    z80_pkg::word_t        pair_data;
    logic                  wr_en;
    z80_pkg::reg_sel_t     wr_sel;
    z80_pkg::byte_t        wr_data;
    logic                  pair_wr_en;
    z80_pkg::pair_sel_t    pair_wr_sel;
    z80_pkg::word_t        pair_wr_data;

    z80_sequencer #(
        .P_RESET_PC (P_RESET_PC)
    ) seq0 (
        .clk            (clk),
        .reset          (reset),
        .mem            (mem_bus.seq),
        .o_opcode       (opcode),
        .i_group        (group),
        .i_len          (len),
        .o_rd_sel       (rd_sel),
        .i_rd_data      (rd_data),
        .o_pair_sel     (pair_sel),
        .i_pair_data    (pair_data),
        .o_wr_en        (wr_en),
        .o_wr_sel       (wr_sel),
        .o_wr_data      (wr_data),
        .o_pair_wr_en   (pair_wr_en),
        .o_pair_wr_sel  (pair_wr_sel),
        .o_pair_wr_data (pair_wr_data),
        .o_insn_done    (o_insn_done)
    );

    z80_decoder dec0 (
        .i_opcode (opcode),
        .o_group  (group),
        .o_len    (len)
    );

    z80_regfile regs0 (
        .clk            (clk),
        .reset          (reset),
        .i_rd_sel       (rd_sel),
        .o_rd_data      (rd_data),
        .i_pair_sel     (pair_sel),
        .o_pair_data    (pair_data),
        .i_wr_en        (wr_en),
        .i_wr_sel       (wr_sel),
        .i_wr_data      (wr_data),
        .i_pair_wr_en   (pair_wr_en),
        .i_pair_wr_sel  (pair_wr_sel),
        .i_pair_wr_data (pair_wr_data)
    );

    z80_apb_master apb0 (
        .clk       (clk),
        .reset     (reset),
        .mem       (mem_bus.bus),
        .o_psel    (o_psel),
        .o_penable (o_penable),
        .o_pwrite  (o_pwrite),
        .o_paddr   (o_paddr),
        .o_pwdata  (o_pwdata),
        .i_prdata  (i_prdata),
        .i_pready  (i_pready)
    );

endmodule

//--- src/z80_sequencer.sv
module z80_sequencer #(
    parameter z80_pkg::addr_t P_RESET_PC = 16'h0000
) (
    input  logic                  clk,
    input  logic                  reset,
    z80_mem_if.seq                mem,
    output z80_pkg::byte_t        o_opcode,
    input  z80_pkg::insn_group_t  i_group,
    input  z80_pkg::insn_len_t    i_len,
    output z80_pkg::reg_sel_t     o_rd_sel,
    input  z80_pkg::byte_t        i_rd_data,
    output z80_pkg::pair_sel_t    o_pair_sel,
    input  z80_pkg::word_t        i_pair_data,
    output logic                  o_wr_en,
    output z80_pkg::reg_sel_t     o_wr_sel,
    output z80_pkg::byte_t        o_wr_data,
    output logic                  o_pair_wr_en,
    output z80_pkg::pair_sel_t    o_pair_wr_sel,
    output z80_pkg::word_t        o_pair_wr_data,
    output logic                  o_insn_done
);

    typedef enum logic [1:0] {
        FETCH_OP,
        FETCH_OPERAND,
        DATA_ACCESS,
        DONE
    } phase_t;

    phase_t          phase;
    phase_t          next_phase;
    z80_pkg::addr_t  pc;
    z80_pkg::byte_t  opcode_q;
    z80_pkg::byte_t  lo_q;
    z80_pkg::byte_t  hi_q;
    logic            operand_idx;
    logic            last_byte;
    logic            needs_data;
    logic            data_write;
    logic            direct_addr;

    // Decode the opcode byte in the same cycle it arrives
    assign o_opcode = (phase == FETCH_OP) ? mem.rdata : opcode_q;

    assign needs_data = i_group inside {
        z80_pkg::GRP_LD_A_BCDE, z80_pkg::GRP_LD_BCDE_A, z80_pkg::GRP_LD_A_NN,
        z80_pkg::GRP_LD_NN_A, z80_pkg::GRP_LD_R_HL, z80_pkg::GRP_LD_HL_R,
        z80_pkg::GRP_LD_HL_N};
    assign data_write = i_group inside {
        z80_pkg::GRP_LD_BCDE_A, z80_pkg::GRP_LD_NN_A,
        z80_pkg::GRP_LD_HL_R, z80_pkg::GRP_LD_HL_N};
    assign direct_addr = i_group inside {z80_pkg::GRP_LD_A_NN, z80_pkg::GRP_LD_NN_A};

    always_comb begin
        next_phase = phase;
        last_byte  = 1'b0;
        case (phase)
            FETCH_OP: begin
                if (mem.ack) begin
                    if (i_len == 2'd1) begin
                        last_byte = 1'b1;
                    end else begin
                        next_phase = FETCH_OPERAND;
                    end
                end
            end
            FETCH_OPERAND: begin
                if (mem.ack && (operand_idx || i_len == 2'd2)) begin
                    last_byte = 1'b1;
                end
            end
            DATA_ACCESS: begin
                if (mem.ack) begin
                    next_phase = DONE;
                end
            end
            default: next_phase = FETCH_OP;
        endcase
        if (last_byte) begin
            next_phase = needs_data ? DATA_ACCESS : DONE;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase       <= FETCH_OP;
            pc          <= P_RESET_PC;
            opcode_q    <= '0;
            operand_idx <= 1'b0;
            o_insn_done <= 1'b0;
        end else begin
            phase       <= next_phase;
            o_insn_done <= (next_phase == DONE);
            if (mem.ack && (phase == FETCH_OP || phase == FETCH_OPERAND)) begin
                pc <= pc + 16'd1;
            end
            if (mem.ack && phase == FETCH_OP) begin
                opcode_q    <= mem.rdata;
                operand_idx <= 1'b0;
            end
            if (mem.ack && phase == FETCH_OPERAND) begin
                operand_idx <= 1'b1;
            end
        end
    end

    // Operand bytes, little endian
    always_ff @(posedge clk) begin
        if (mem.ack && phase == FETCH_OPERAND) begin
            if (operand_idx) begin
                hi_q <= mem.rdata;
            end else begin
                lo_q <= mem.rdata;
            end
        end
    end

    // A transfer is outstanding in every phase, the DONE cycle already fetches
    assign mem.req = 1'b1;

    always_comb begin
        mem.addr  = pc;
        mem.we    = 1'b0;
        mem.wdata = i_rd_data;
        if (phase == DATA_ACCESS) begin
            mem.addr = direct_addr ? {hi_q, lo_q} : i_pair_data;
            mem.we   = data_write;
            if (i_group == z80_pkg::GRP_LD_HL_N) begin
                mem.wdata = lo_q;
            end
        end
    end

    assign o_rd_sel = (i_group inside {z80_pkg::GRP_LD_R_R, z80_pkg::GRP_LD_HL_R}) ?
                      o_opcode[2:0] : z80_pkg::REG_A;
    assign o_pair_sel = (i_group inside {z80_pkg::GRP_LD_A_BCDE, z80_pkg::GRP_LD_BCDE_A}) ?
                        {1'b0, o_opcode[4]} : z80_pkg::PAIR_HL;

    // Results land on the edge that ends the last transfer
    assign o_wr_en =
        (phase == FETCH_OP && mem.ack && i_group == z80_pkg::GRP_LD_R_R) ||
        (phase == FETCH_OPERAND && mem.ack && i_group == z80_pkg::GRP_LD_R_N) ||
        (phase == DATA_ACCESS && mem.ack && needs_data && !data_write);
    assign o_wr_sel = (i_group inside {z80_pkg::GRP_LD_A_BCDE, z80_pkg::GRP_LD_A_NN}) ?
                      z80_pkg::REG_A : o_opcode[5:3];
    assign o_wr_data = (i_group == z80_pkg::GRP_LD_R_R) ? i_rd_data : mem.rdata;

    assign o_pair_wr_en = (phase == FETCH_OPERAND) && mem.ack && operand_idx &&
                          (i_group == z80_pkg::GRP_LD_DD_NN);
    assign o_pair_wr_sel  = o_opcode[5:4];
    assign o_pair_wr_data = {mem.rdata, lo_q};

endmodule

//--- src/z80_apb_master.sv
module z80_apb_master (
    input  logic            clk,
    input  logic            reset,
    z80_mem_if.bus          mem,
    output logic            o_psel,
    output logic            o_penable,
    output logic            o_pwrite,
    output z80_pkg::addr_t  o_paddr,
    output z80_pkg::byte_t  o_pwdata,
    input  z80_pkg::byte_t  i_prdata,
    input  logic            i_pready
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

    apb_state_t state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            o_pwrite <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (mem.req) begin
                        state    <= SETUP;
                        o_pwrite <= mem.we;
                    end
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    // Wait states stretch the access phase
                    if (i_pready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && mem.req) begin
            o_paddr  <= mem.addr;
            o_pwdata <= mem.wdata;
        end
    end

    assign o_psel    = (state != IDLE);
    assign o_penable = (state == ACCESS);
    assign mem.ack   = (state == ACCESS) && i_pready;
    assign mem.rdata = i_prdata;

endmodule

//--- src/z80_regfile.sv
module z80_regfile (
    input  logic                clk,
    input  logic                reset,
    input  z80_pkg::reg_sel_t   i_rd_sel,
    output z80_pkg::byte_t      o_rd_data,
    input  z80_pkg::pair_sel_t  i_pair_sel,
    output z80_pkg::word_t      o_pair_data,
    input  logic                i_wr_en,
    input  z80_pkg::reg_sel_t   i_wr_sel,
    input  z80_pkg::byte_t      i_wr_data,
    input  logic                i_pair_wr_en,
    input  z80_pkg::pair_sel_t  i_pair_wr_sel,
    input  z80_pkg::word_t      i_pair_wr_data
);

    z80_pkg::byte_t reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a;
    z80_pkg::word_t reg_sp;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_b  <= '0;
            reg_c  <= '0;
            reg_d  <= '0;
            reg_e  <= '0;
            reg_h  <= '0;
            reg_l  <= '0;
            reg_a  <= '0;
            reg_sp <= '0;
        end else begin
            if (i_pair_wr_en) begin
                case (i_pair_wr_sel)
                    2'd0: {reg_b, reg_c} <= i_pair_wr_data;
                    2'd1: {reg_d, reg_e} <= i_pair_wr_data;
                    2'd2: {reg_h, reg_l} <= i_pair_wr_data;
                    default: reg_sp <= i_pair_wr_data;
                endcase
            end
            if (i_wr_en) begin
                case (i_wr_sel)
                    3'd0: reg_b <= i_wr_data;
                    3'd1: reg_c <= i_wr_data;
                    3'd2: reg_d <= i_wr_data;
                    3'd3: reg_e <= i_wr_data;
                    3'd4: reg_h <= i_wr_data;
                    3'd5: reg_l <= i_wr_data;
                    3'd7: reg_a <= i_wr_data;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (i_rd_sel)
            3'd0: o_rd_data = reg_b;
            3'd1: o_rd_data = reg_c;
            3'd2: o_rd_data = reg_d;
            3'd3: o_rd_data = reg_e;
            3'd4: o_rd_data = reg_h;
            3'd5: o_rd_data = reg_l;
            3'd7: o_rd_data = reg_a;
            default: o_rd_data = '0;
        endcase
    end

    always_comb begin
        case (i_pair_sel)
            2'd0: o_pair_data = {reg_b, reg_c};
            2'd1: o_pair_data = {reg_d, reg_e};
            2'd2: o_pair_data = {reg_h, reg_l};
            default: o_pair_data = reg_sp;
        endcase
    end

endmodule

//--- src/z80_decoder.sv
module z80_decoder (
    input  z80_pkg::byte_t       i_opcode,
    output z80_pkg::insn_group_t o_group,
    output z80_pkg::insn_len_t   o_len
);

    always_comb begin
        o_group = z80_pkg::GRP_NOP;
        o_len   = 2'd1;
        case (i_opcode[7:6])
            2'b00: begin
                if (i_opcode[3:0] == 4'h1) begin
                    o_group = z80_pkg::GRP_LD_DD_NN;
                    o_len   = 2'd3;
                end else if (i_opcode[2:0] == 3'b110) begin
                    o_len = 2'd2;
                    if (i_opcode[5:3] == z80_pkg::REG_HL_IND) begin
                        o_group = z80_pkg::GRP_LD_HL_N;
                    end else begin
                        o_group = z80_pkg::GRP_LD_R_N;
                    end
                end else if (i_opcode[2:0] == 3'b010) begin
                    // 22 and 2A are 16-bit memory loads, left as no-ops
                    case (i_opcode[5:3])
                        3'b000, 3'b010: o_group = z80_pkg::GRP_LD_BCDE_A;
                        3'b001, 3'b011: o_group = z80_pkg::GRP_LD_A_BCDE;
                        3'b110: begin
                            o_group = z80_pkg::GRP_LD_NN_A;
                            o_len   = 2'd3;
                        end
                        3'b111: begin
                            o_group = z80_pkg::GRP_LD_A_NN;
                            o_len   = 2'd3;
                        end
                        default: o_group = z80_pkg::GRP_NOP;
                    endcase
                end
            end
            2'b01: begin
                // 0x76 is HALT, not supported
                if (i_opcode[5:3] == z80_pkg::REG_HL_IND &&
                    i_opcode[2:0] == z80_pkg::REG_HL_IND) begin
                    o_group = z80_pkg::GRP_NOP;
                end else if (i_opcode[2:0] == z80_pkg::REG_HL_IND) begin
                    o_group = z80_pkg::GRP_LD_R_HL;
                end else if (i_opcode[5:3] == z80_pkg::REG_HL_IND) begin
                    o_group = z80_pkg::GRP_LD_HL_R;
                end else begin
                    o_group = z80_pkg::GRP_LD_R_R;
                end
            end
            default: o_group = z80_pkg::GRP_NOP;
        endcase
    end

endmodule

//--- src/z80_mem_if.sv
interface z80_mem_if;

    logic            req;
    logic            we;
    z80_pkg::addr_t  addr;
    z80_pkg::byte_t  wdata;
    logic            ack;
    z80_pkg::byte_t  rdata;

    modport seq (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport bus (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

//--- src/z80_pkg.sv
package z80_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // Z80 register field encoding, 6 selects (HL) in memory
    typedef logic [2:0] reg_sel_t;
    typedef logic [1:0] pair_sel_t;

    localparam reg_sel_t  REG_A      = 3'd7;
    localparam reg_sel_t  REG_HL_IND = 3'd6;
    localparam pair_sel_t PAIR_HL    = 2'd2;

    // Total instruction length in bytes, 1 to 3
    typedef logic [1:0] insn_len_t;

    typedef enum logic [3:0] {
        GRP_NOP,
        GRP_LD_R_R,
        GRP_LD_R_N,
        GRP_LD_DD_NN,
        GRP_LD_A_BCDE,
        GRP_LD_BCDE_A,
        GRP_LD_A_NN,
        GRP_LD_NN_A,
        GRP_LD_R_HL,
        GRP_LD_HL_R,
        GRP_LD_HL_N
    } insn_group_t;

endpackage
